/* dv/flane_rom_patterns.txt */
// Columns: op (1 hex), byte or word address (7 hex), data (4 hex)
// op 1 download byte, 2 gfx read, 3 pcm read, 4 main read, 5 all slots (gfx word)
1000001000A1
1000001100B2
1000001200C3
1000001300D4
10000004007B
10000005004C
10020008005E
100200090017
1002000A009C
1002000B000F
100A0020003A
100A0021006D
100A000400E2
100A00050081
101400000055
1014000100AA
500000045E17
500000059C0F
200000045E17
30000021006D
30000020003A
4000001000A1
4000001300D4
4000001100B2

/* flane_rom.f */
+incdir+rtl
rtl/flane_pkg.sv
rtl/flane_dwnld.sv
rtl/flane_rom_slot.sv
rtl/flane_rom_arb.sv
rtl/flane_rom.sv
dv/flane_rom_chk.sv
dv/flane_rom_tb.sv

/* Makefile */
# Verilator build and run for the ROM side testbench

TOP = flane_rom_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f flane_rom.f --top-module $(TOP) -Mdir obj_dir

run: compile
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

/* dv/flane_rom_tb.sv */
// Testbench for the ROM side top level
// Replays the download bytes and then the slot reads from dv/flane_rom_patterns.txt
// The SDRAM model answers prog writes and reads after LFSR picked delays
// Run from the project root so the pattern file path resolves

`timescale 1ns/1ps

`include "flane_consts.svh"

module flane_rom_tb;

    localparam int MAX_OPS = 64;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      downloading;
    logic [24:0]               ioctl_addr;
    flane_pkg::byte_t          ioctl_dout;
    logic                      ioctl_wr;
    flane_pkg::sdram_addr_t    prog_addr;
    flane_pkg::byte_t          prog_data;
    logic [1:0]                prog_mask;
    logic                      prog_we;
    logic                      prom_we;
    logic                      dwnld_busy;
    logic                      sdram_ack = 1'b0;
    logic                      data_dst  = 1'b0;
    logic                      data_rdy  = 1'b0;
    flane_pkg::word_t          data_read = '0;
    logic                      sdram_req;
    flane_pkg::sdram_addr_t    sdram_addr;
    logic                      gfx_cs;
    logic [`FLANE_GFX_AW-1:0]  gfx_addr;
    flane_pkg::word_t          gfx_data;
    logic                      gfx_ok;
    logic                      pcm_cs;
    logic [`FLANE_PCM_AW-1:0]  pcm_addr;
    flane_pkg::byte_t          pcm_data;
    logic                      pcm_ok;
    logic                      main_cs;
    logic [`FLANE_MAIN_AW-1:0] main_addr;
    flane_pkg::byte_t          main_data;
    logic                      main_ok;

    logic [47:0]               ops [MAX_OPS];   // Op, address and data
    int                        n_ops;
    int                        cycle_count = 0;
    int                        cycle_limit = 100;
    int                        check_count = 0;
    int                        error_count = 0;
    logic [15:0]               lfsr = 16'd23;

    // SDRAM model state
    flane_pkg::word_t          mem [flane_pkg::sdram_addr_t];
    int                        ack_cnt  = -1;   // Idle when negative
    int                        dst_cnt  = 0;
    logic                      rdy_next = 1'b0;
    flane_pkg::sdram_addr_t    rd_addr  = '0;

    flane_rom flane_rom_i (.*);

    bind flane_rom flane_rom_chk chk_i (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .sdram_req   ( sdram_req   ),
        .sdram_ack   ( sdram_ack   ),
        .sdram_addr  ( sdram_addr  ),
        .prog_we     ( prog_we     ),
        .prog_addr   ( prog_addr   ),
        .gfx_cs      ( gfx_cs      ),
        .gfx_ok      ( gfx_ok      ),
        .pcm_cs      ( pcm_cs      ),
        .pcm_ok      ( pcm_ok      ),
        .main_cs     ( main_cs     ),
        .main_ok     ( main_ok     )
    );

    always #5 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_random_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int ack_delay();
        logic b1;
        logic b0;
        b1 = next_random_bit();
        b0 = next_random_bit();
        return int'({b1, b0});
    endfunction

    // Unwritten words read back an address dependent fill
    function automatic flane_pkg::word_t mem_read(input flane_pkg::sdram_addr_t wa);
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return wa[15:0] ^ {10'h0, wa[21:16]};
    endfunction

    // Even byte sits in the high lane
    function automatic flane_pkg::byte_t word_byte(input flane_pkg::sdram_addr_t wa,
                                                   input logic lsb);
        flane_pkg::word_t w;
        w = mem_read(wa);
        return lsb ? w[7:0] : w[15:8];
    endfunction

    task automatic apply_prog_write();
        flane_pkg::word_t w;
        w = mem_read(prog_addr);
        if (!prog_mask[0]) begin
            w[7:0] = prog_data;
        end
        if (!prog_mask[1]) begin
            w[15:8] = prog_data;
        end
        mem[prog_addr] = w;
    endtask

    // SDRAM model acks after 0 to 3 cycles, then dst two cycles later and rdy one after
    always @(posedge clk) begin
        #1;
        sdram_ack = 1'b0;
        data_dst  = 1'b0;
        data_rdy  = 1'b0;
        if (!rst_n) begin
            ack_cnt  = -1;
            dst_cnt  = 0;
            rdy_next = 1'b0;
        end else begin
            if (rdy_next) begin
                data_rdy  = 1'b1;
                data_read = mem_read(rd_addr);
                rdy_next  = 1'b0;
            end
            if (dst_cnt > 0) begin
                dst_cnt--;
                if (dst_cnt == 0) begin
                    data_dst = 1'b1;
                    rdy_next = 1'b1;
                end
            end
            if (ack_cnt < 0 && (prog_we || sdram_req)) begin
                ack_cnt = ack_delay();
            end
            if (ack_cnt == 0) begin
                sdram_ack = 1'b1;
                ack_cnt   = -1;
                if (prog_we) begin
                    apply_prog_write();
                end
                if (sdram_req) begin
                    rd_addr = sdram_addr;
                    dst_cnt = 2;
                end
            end else if (ack_cnt > 0) begin
                ack_cnt--;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic drive_slot(input int slot, input logic cs, input logic [16:0] a);
        case (slot)
            0: begin
                gfx_cs   = cs;
                gfx_addr = a;
            end
            1: begin
                pcm_cs   = cs;
                pcm_addr = a;
            end
            default: begin
                main_cs   = cs;
                main_addr = a;
            end
        endcase
    endtask

    function automatic logic slot_ok(input int slot);
        case (slot)
            0:       return gfx_ok;
            1:       return pcm_ok;
            default: return main_ok;
        endcase
    endfunction

    function automatic logic [15:0] slot_data(input int slot);
        case (slot)
            0:       return gfx_data;
            1:       return {8'h00, pcm_data};
            default: return {8'h00, main_data};
        endcase
    endfunction

    task automatic set_download(input logic level);
        @(posedge clk);
        #1;
        downloading = level;
        @(negedge clk);
        check_count++;
        if (dwnld_busy !== level) begin
            error_count++;
            $display("Error at %0t: dwnld_busy is %b, expected %b", $time, dwnld_busy, level);
        end
    endtask

    task automatic download_byte(input logic [24:0] a, input flane_pkg::byte_t b);
        logic       is_prom;
        logic [1:0] exp_mask;
        is_prom  = a >= `FLANE_PROM_START;
        exp_mask = a[0] ? 2'b10 : 2'b01;
        @(posedge clk);
        #1;
        ioctl_addr = a;
        ioctl_dout = b;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #1;
        ioctl_wr = 1'b0;
        @(negedge clk);
        check_count++;
        if (is_prom) begin
            if (!prom_we || prog_we) begin
                error_count++;
                $display("Error at %0t: PROM byte %h gave prom_we %b prog_we %b",
                         $time, a, prom_we, prog_we);
            end
            @(negedge clk);
            if (prom_we || prog_we) begin
                error_count++;
                $display("Error at %0t: PROM strobe for byte %h lasted too long", $time, a);
            end
        end else begin
            if (!prog_we || prog_addr !== 22'(a >> 1) || prog_data !== b ||
                prog_mask !== exp_mask) begin
                error_count++;
                $display("Error at %0t: byte %h gave prog addr %h data %h mask %b we %b",
                         $time, a, prog_addr, prog_data, prog_mask, prog_we);
            end
            while (prog_we) begin
                @(negedge clk);
            end
            check_count++;
            if (word_byte(22'(a >> 1), a[0]) !== b) begin
                error_count++;
                $display("Error at %0t: model memory holds %h at byte %h, expected %h",
                         $time, word_byte(22'(a >> 1), a[0]), a, b);
            end
        end
    endtask

    task automatic read_one(input int slot, input logic [16:0] a, input logic [15:0] exp);
        @(posedge clk);
        #1;
        drive_slot(slot, 1'b1, a);
        @(negedge clk);
        while (!slot_ok(slot)) begin
            @(negedge clk);
        end
        check_count++;
        if (slot_data(slot) !== exp) begin
            error_count++;
            $display("Error at %0t: slot %0d addr %h read %h, expected %h",
                     $time, slot, a, slot_data(slot), exp);
        end
        // Same address again must hit the cache at once
        @(posedge clk);
        #1;
        drive_slot(slot, 1'b0, a);
        @(posedge clk);
        #1;
        drive_slot(slot, 1'b1, a);
        @(negedge clk);
        check_count++;
        if (!slot_ok(slot) || sdram_req) begin
            error_count++;
            $display("Error at %0t: slot %0d repeat at %h gave ok %b sdram_req %b",
                     $time, slot, a, slot_ok(slot), sdram_req);
        end
        // A hit leaves the SDRAM idle while cs stays high
        repeat (3) begin
            @(negedge clk);
            check_count++;
            if (!slot_ok(slot) || sdram_req) begin
                error_count++;
                $display("Error at %0t: slot %0d held at %h gave ok %b sdram_req %b",
                         $time, slot, a, slot_ok(slot), sdram_req);
            end
        end
        @(posedge clk);
        #1;
        drive_slot(slot, 1'b0, a);
    endtask

    task automatic read_all(input logic [16:0] a, input logic [15:0] exp_gfx);
        flane_pkg::byte_t exp_pcm;
        flane_pkg::byte_t exp_main;
        exp_pcm  = word_byte(`FLANE_PCM_OFFSET + 22'(a >> 1), a[0]);
        exp_main = word_byte(`FLANE_MAIN_OFFSET + 22'(a >> 1), a[0]);
        @(posedge clk);
        #1;
        drive_slot(0, 1'b1, a);
        drive_slot(1, 1'b1, a);
        drive_slot(2, 1'b1, a);
        @(negedge clk);
        while (!(gfx_ok && pcm_ok && main_ok)) begin
            @(negedge clk);
        end
        check_count++;
        if (gfx_data !== exp_gfx || pcm_data !== exp_pcm || main_data !== exp_main) begin
            error_count++;
            $display("Error at %0t: all slots at %h read %h %h %h, expected %h %h %h",
                     $time, a, gfx_data, pcm_data, main_data, exp_gfx, exp_pcm, exp_main);
        end
        @(posedge clk);
        #1;
        drive_slot(0, 1'b0, a);
        drive_slot(1, 1'b0, a);
        drive_slot(2, 1'b0, a);
    endtask

    initial begin
        logic [3:0]  op;
        logic [24:0] a;
        logic [15:0] d;
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        gfx_cs      = 1'b0;
        gfx_addr    = '0;
        pcm_cs      = 1'b0;
        pcm_addr    = '0;
        main_cs     = 1'b0;
        main_addr   = '0;
        for (int i = 0; i < MAX_OPS; i++) begin
            ops[i] = '0;
        end
        $readmemh("dv/flane_rom_patterns.txt", ops);
        n_ops = 0;
        while (n_ops < MAX_OPS && ops[n_ops][47:44] != 4'h0) begin
            n_ops++;
        end
        cycle_limit = 40 * n_ops + 100;
        if (n_ops == 0) begin
            error_count++;
            $display("No operations were read from the pattern file");
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < n_ops; i++) begin
            op = ops[i][47:44];
            a  = ops[i][40:16];
            d  = ops[i][15:0];
            if (op == 4'h1 && !downloading) begin
                set_download(1'b1);
            end else if (op != 4'h1 && downloading) begin
                set_download(1'b0);
            end
            case (op)
                4'h1:    download_byte(a, d[7:0]);
                4'h2:    read_one(0, a[16:0], d);
                4'h3:    read_one(1, a[16:0], d);
                4'h4:    read_one(2, a[16:0], d);
                4'h5:    read_all(a[16:0], d);
                default: begin
                    error_count++;
                    $display("Unknown operation %h in pattern entry %0d", op, i);
                end
            endcase
        end
        if (downloading) begin
            set_download(1'b0);
        end
        repeat (2) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* dv/flane_rom_chk.sv */
// Protocol assertions for the ROM side top level
// Bound into flane_rom from the testbench, failures show up as $error

`timescale 1ns/1ps

module flane_rom_chk (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   downloading,
    input logic                   sdram_req,
    input logic                   sdram_ack,
    input flane_pkg::sdram_addr_t sdram_addr,
    input logic                   prog_we,
    input flane_pkg::sdram_addr_t prog_addr,
    input logic                   gfx_cs,
    input logic                   gfx_ok,
    input logic                   pcm_cs,
    input logic                   pcm_ok,
    input logic                   main_cs,
    input logic                   main_ok
);

    // Read request held with its address until the memory takes it
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else $error("sdram_req or sdram_addr moved before sdram_ack");

    prog_hold: assert property (@(posedge clk) disable iff (!rst_n)
        prog_we && !sdram_ack |=> prog_we && $stable(prog_addr))
        else $error("prog_we or prog_addr moved before sdram_ack");

    // Download owns the SDRAM
    no_read_in_dwnld: assert property (@(posedge clk) disable iff (!rst_n)
        downloading |-> !sdram_req)
        else $error("sdram_req raised while downloading");

    ok_needs_cs: assert property (@(posedge clk) disable iff (!rst_n)
        (!gfx_ok || gfx_cs) && (!pcm_ok || pcm_cs) && (!main_ok || main_cs))
        else $error("a slot ok was high without its cs");

endmodule

/* rtl/flane_rom.sv */
// ROM side top level of the arcade core
// Loads the game image into SDRAM and serves graphics, PCM and main CPU reads
// Slot 0 is graphics (16 bits), slot 1 PCM and slot 2 main ROM (8 bits)

`timescale 1ns/1ps

`include "flane_consts.svh"

module flane_rom (
    input  logic                        clk,
    input  logic                        rst_n,
    // Download
    input  logic                        downloading,
    input  logic [24:0]                 ioctl_addr,
    input  flane_pkg::byte_t            ioctl_dout,
    input  logic                        ioctl_wr,
    output flane_pkg::sdram_addr_t      prog_addr,
    output flane_pkg::byte_t            prog_data,
    output logic [1:0]                  prog_mask,
    output logic                        prog_we,
    output logic                        prom_we,
    output logic                        dwnld_busy,
    // SDRAM
    input  logic                        sdram_ack,
    input  logic                        data_dst,
    input  logic                        data_rdy,
    input  flane_pkg::word_t            data_read,
    output logic                        sdram_req,
    output flane_pkg::sdram_addr_t      sdram_addr,
    // Requesters
    input  logic                        gfx_cs,
    input  logic [`FLANE_GFX_AW-1:0]    gfx_addr,
    output flane_pkg::word_t            gfx_data,
    output logic                        gfx_ok,
    input  logic                        pcm_cs,
    input  logic [`FLANE_PCM_AW-1:0]    pcm_addr,
    output flane_pkg::byte_t            pcm_data,
    output logic                        pcm_ok,
    input  logic                        main_cs,
    input  logic [`FLANE_MAIN_AW-1:0]   main_addr,
    output flane_pkg::byte_t            main_data,
    output logic                        main_ok
);

    flane_pkg::slot_req_t slot_req [`FLANE_SLOTS];
    flane_pkg::slot_rsp_t slot_rsp [`FLANE_SLOTS];

    assign dwnld_busy = downloading;

    flane_dwnld u_dwnld (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .downloading ( downloading  ),
        .ioctl_addr  ( ioctl_addr   ),
        .ioctl_dout  ( ioctl_dout   ),
        .ioctl_wr    ( ioctl_wr     ),
        .sdram_ack   ( sdram_ack    ),
        .prog_addr   ( prog_addr    ),
        .prog_data   ( prog_data    ),
        .prog_mask   ( prog_mask    ),
        .prog_we     ( prog_we      ),
        .prom_we     ( prom_we      )
    );

    flane_rom_slot #(.data_t(flane_pkg::word_t), .AW(`FLANE_GFX_AW)) u_gfx (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .downloading ( downloading  ),
        .cs          ( gfx_cs       ),
        .addr        ( gfx_addr     ),
        .rsp         ( slot_rsp[0]  ),
        .dout        ( gfx_data     ),
        .ok          ( gfx_ok       ),
        .req         ( slot_req[0]  )
    );

    flane_rom_slot #(.data_t(flane_pkg::byte_t), .AW(`FLANE_PCM_AW)) u_pcm (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .downloading ( downloading  ),
        .cs          ( pcm_cs       ),
        .addr        ( pcm_addr     ),
        .rsp         ( slot_rsp[1]  ),
        .dout        ( pcm_data     ),
        .ok          ( pcm_ok       ),
        .req         ( slot_req[1]  )
    );

    flane_rom_slot #(.data_t(flane_pkg::byte_t), .AW(`FLANE_MAIN_AW)) u_main (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .downloading ( downloading  ),
        .cs          ( main_cs      ),
        .addr        ( main_addr    ),
        .rsp         ( slot_rsp[2]  ),
        .dout        ( main_data    ),
        .ok          ( main_ok      ),
        .req         ( slot_req[2]  )
    );

    flane_rom_arb u_arb (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .downloading ( downloading  ),
        .req         ( slot_req     ),
        .sdram_ack   ( sdram_ack    ),
        .data_dst    ( data_dst     ),
        .data_rdy    ( data_rdy     ),
        .data_read   ( data_read    ),
        .rsp         ( slot_rsp     ),
        .sdram_req   ( sdram_req    ),
        .sdram_addr  ( sdram_addr   )
    );

endmodule

/* rtl/flane_rom_arb.sv */
// SDRAM read arbiter for the ROM slots
// Fixed priority, slot 0 first. One read in flight at a time
// Adds the slot region offset and hands the returned word back with a done pulse
// Stays idle during download so prog writes own the SDRAM

`timescale 1ns/1ps

`include "flane_consts.svh"

module flane_rom_arb (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    downloading,
    input  flane_pkg::slot_req_t    req [`FLANE_SLOTS],
    input  logic                    sdram_ack,
    input  logic                    data_dst,
    input  logic                    data_rdy,
    input  flane_pkg::word_t        data_read,
    output flane_pkg::slot_rsp_t    rsp [`FLANE_SLOTS],
    output logic                    sdram_req,
    output flane_pkg::sdram_addr_t  sdram_addr
);

    localparam int IW = $clog2(`FLANE_SLOTS);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait
    } state_t;

    state_t                  state;
    logic [IW-1:0]           sel;      // Granted slot
    logic [IW-1:0]           pick;
    logic                    any_req;
    logic                    burst;
    logic [`FLANE_SLOTS-1:0] done_q;
    flane_pkg::word_t        rd_word;

    function automatic flane_pkg::sdram_addr_t slot_offset(input logic [IW-1:0] idx);
        case (idx)
            IW'(0):  slot_offset = `FLANE_GFX_OFFSET;
            IW'(1):  slot_offset = `FLANE_PCM_OFFSET;
            default: slot_offset = `FLANE_MAIN_OFFSET;
        endcase
    endfunction

    // Lowest index wins, loop runs downwards so it is assigned last
    always_comb begin
        any_req = 1'b0;
        pick    = '0;
        for (int i = `FLANE_SLOTS - 1; i >= 0; i--) begin
            if (req[i].req) begin
                any_req = 1'b1;
                pick    = IW'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            sdram_req <= 1'b0;
            burst     <= 1'b0;
            done_q    <= '0;
        end else begin
            done_q <= '0;
            case (state)
                st_idle: begin
                    // Skip the done cycle, the served slot still shows req
                    if (!downloading && any_req && done_q == '0) begin
                        sdram_req <= 1'b1;
                        state     <= st_req;
                    end
                end
                st_req: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= st_wait;
                    end
                end
                st_wait: begin
                    if (data_dst) begin
                        burst <= 1'b1;
                    end
                    if (data_rdy && (burst || data_dst)) begin
                        burst       <= 1'b0;
                        done_q[sel] <= 1'b1;
                        state       <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            sel        <= pick;
            sdram_addr <= req[pick].addr + slot_offset(pick);
        end
        if (state == st_wait && data_rdy) begin
            rd_word <= data_read;
        end
    end

    generate
        for (genvar i = 0; i < `FLANE_SLOTS; i++) begin : g_rsp
            assign rsp[i].done = done_q[i];
            assign rsp[i].data = (sel == IW'(i)) ? rd_word : '0;   // Granted slot only
        end
    endgenerate

endmodule

/* rtl/flane_rom_slot.sv */
// ROM port of one requester
// Keeps the last fetched SDRAM word and answers hits in the same cycle
// A miss raises req toward the arbiter until the done pulse comes back
// data_t picks a 16-bit or an 8-bit payload, AW is the requester address width

`timescale 1ns/1ps

module flane_rom_slot #(
    parameter type data_t = flane_pkg::word_t,
    parameter int  AW     = 17
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  downloading,
    input  logic                  cs,
    input  logic [AW-1:0]         addr,
    input  flane_pkg::slot_rsp_t  rsp,
    output data_t                 dout,
    output logic                  ok,
    output flane_pkg::slot_req_t  req
);

    localparam int DW  = $bits(data_t);
    localparam int SAW = $bits(flane_pkg::sdram_addr_t);

    logic [AW-1:0]    cur_wa;       // Word address of the current request
    logic [AW-1:0]    cache_wa;
    logic [AW-1:0]    req_wa;
    flane_pkg::word_t cache_word;
    logic             valid;
    logic             pending;
    logic             hit;
    logic             miss;

    generate
        if (DW == 8) begin : g_byte
            assign cur_wa = {1'b0, addr[AW-1:1]};
            // High byte first to match the swapped image
            assign dout   = addr[0] ? cache_word[7:0] : cache_word[15:8];
        end else begin : g_word
            assign cur_wa = addr;
            assign dout   = cache_word;
        end
    endgenerate

    // Combinational so ok drops as soon as addr moves
    assign hit  = valid && (cache_wa == cur_wa);
    assign miss = cs && !hit && !pending;
    assign ok   = cs && hit;

    assign req.req  = pending;
    assign req.addr = {{(SAW-AW){1'b0}}, req_wa};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid   <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (rsp.done) begin
                pending <= 1'b0;
                valid   <= 1'b1;
            end else if (miss && !downloading) begin
                pending <= 1'b1;
            end
            // SDRAM contents are changing
            if (downloading) begin
                valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp.done) begin
            cache_word <= rsp.data;
            cache_wa   <= req_wa;
        end
        if (miss) begin
            req_wa <= cur_wa;   // Frozen while pending
        end
    end

endmodule

/* rtl/flane_dwnld.sv */
// Download port to SDRAM write converter
// Each ioctl byte becomes a prog write one cycle later, held until sdram_ack
// Bytes past the PROM start only strobe prom_we, with a PROM relative address

`timescale 1ns/1ps

`include "flane_consts.svh"

module flane_dwnld (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    downloading,
    input  logic [24:0]             ioctl_addr,
    input  flane_pkg::byte_t        ioctl_dout,
    input  logic                    ioctl_wr,
    input  logic                    sdram_ack,
    output flane_pkg::sdram_addr_t  prog_addr,
    output flane_pkg::byte_t        prog_data,
    output logic [1:0]              prog_mask,   // Active low
    output logic                    prog_we,
    output logic                    prom_we
);

    logic        wr_ev;
    logic        is_prom;
    logic [24:0] prom_off;

    assign wr_ev    = downloading & ioctl_wr;
    assign is_prom  = ioctl_addr >= `FLANE_PROM_START;
    assign prom_off = ioctl_addr - `FLANE_PROM_START;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= wr_ev & is_prom;   // Single cycle strobe
            if (wr_ev && !is_prom) begin
                prog_we <= 1'b1;
            end else if (sdram_ack) begin
                prog_we <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ev) begin
            prog_data <= ioctl_dout;
            if (is_prom) begin
                prog_addr <= prom_off[21:0];   // Byte index inside the PROM area
                prog_mask <= 2'b11;
            end else begin
                prog_addr <= ioctl_addr[22:1];
                // Image is byte swapped, even bytes go to the high lane
                prog_mask <= ioctl_addr[0] ? 2'b10 : 2'b01;
            end
        end
    end

endmodule

/* rtl/flane_pkg.sv */
// Types shared by the ROM side RTL and its testbench
// Slots talk to the arbiter with slot_req_t and get slot_rsp_t back
// Referenced with scoped names, no import needed

package flane_pkg;

    // SDRAM data is 16 bits wide, game ROMs are byte oriented
    typedef logic [15:0] word_t;
    typedef logic [ 7:0] byte_t;

    typedef logic [21:0] sdram_addr_t;   // Word address

    // Slot to arbiter
    typedef struct packed {
        logic        req;    // Held until done
        sdram_addr_t addr;   // Slot word address, no offset yet
    } slot_req_t;

    // Arbiter to slot
    typedef struct packed {
        logic  done;         // One cycle pulse
        word_t data;
    } slot_rsp_t;

endpackage

/* rtl/flane_consts.svh */
// Memory map and slot geometry of the ROM side
// Include wherever an offset, the PROM start or a slot width is needed

`ifndef FLANE_CONSTS_SVH
`define FLANE_CONSTS_SVH

// SDRAM word offsets of each requester's region
`define FLANE_GFX_OFFSET  22'h01_0000
`define FLANE_PCM_OFFSET  22'h05_0000
`define FLANE_MAIN_OFFSET 22'h00_0000

// Byte address in the download image, PROMs live above it
`define FLANE_PROM_START  25'h14_0000

// Slot address widths
`define FLANE_GFX_AW  17
`define FLANE_PCM_AW  17
`define FLANE_MAIN_AW 17

`define FLANE_SLOTS 3

`endif
